//--- rtl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and register file
`define MIPS_XLEN      32
`define MIPS_REG_AW    5
`define MIPS_NUM_REGS  32

// instruction field positions
`define MIPS_OP_LSB    26
`define MIPS_RS_LSB    21
`define MIPS_RT_LSB    16
`define MIPS_RD_LSB    11
`define MIPS_SA_LSB    6

// field widths
`define MIPS_OP_W      6   // opcode and funct
`define MIPS_SHAMT_W   5
`define MIPS_IMM_W     16

`endif

//--- rtl/mips_pkg.sv
package mips_pkg;

    // primary opcode field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

endpackage

//--- rtl/mips_decode.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  logic [`MIPS_XLEN-1:0]   issue_inst,
    input  logic                    ex_we,
    input  logic [`MIPS_REG_AW-1:0] ex_waddr,
    input  logic [`MIPS_XLEN-1:0]   ex_result,
    input  logic                    ret_we,
    input  logic [`MIPS_REG_AW-1:0] ret_waddr,
    input  logic [`MIPS_XLEN-1:0]   ret_data,
    output logic [`MIPS_REG_AW-1:0] rf_raddr1,
    output logic [`MIPS_REG_AW-1:0] rf_raddr2,
    input  logic [`MIPS_XLEN-1:0]   rf_rdata1,
    input  logic [`MIPS_XLEN-1:0]   rf_rdata2,
    output logic                    id_we,
    output logic [`MIPS_REG_AW-1:0] id_waddr,
    output mips_pkg::alu_op_e       id_alu_op,
    output logic [`MIPS_XLEN-1:0]   id_src1,
    output logic [`MIPS_XLEN-1:0]   id_src2
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0]    inst_q;
    logic                     inst_vld;
    opcode_e                  op;
    funct_e                   funct;
    logic [`MIPS_REG_AW-1:0]  rs;
    logic [`MIPS_REG_AW-1:0]  rt;
    logic [`MIPS_REG_AW-1:0]  rd;
    logic [`MIPS_SHAMT_W-1:0] shamt;
    logic [`MIPS_IMM_W-1:0]   imm16;
    logic [`MIPS_XLEN-1:0]    imm_zx;
    logic [`MIPS_XLEN-1:0]    imm_sx;
    logic [`MIPS_XLEN-1:0]    imm;
    logic [`MIPS_XLEN-1:0]    sh_src;
    logic                     re1;
    logic                     re2;
    logic                     wr_en;
    logic                     dst_rt;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_vld <= 1'b0;
        end else begin
            inst_vld <= issue; // bus gap -> bubble
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inst_q <= issue_inst;
        end
    end

    assign op     = opcode_e'(inst_q[`MIPS_OP_LSB +: `MIPS_OP_W]);
    assign funct  = funct_e'(inst_q[`MIPS_OP_W-1:0]);
    assign rs     = inst_q[`MIPS_RS_LSB +: `MIPS_REG_AW];
    assign rt     = inst_q[`MIPS_RT_LSB +: `MIPS_REG_AW];
    assign rd     = inst_q[`MIPS_RD_LSB +: `MIPS_REG_AW];
    assign shamt  = inst_q[`MIPS_SA_LSB +: `MIPS_SHAMT_W];
    assign imm16  = inst_q[`MIPS_IMM_W-1:0];
    assign imm_zx = {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm16};
    assign imm_sx = {{(`MIPS_XLEN-`MIPS_IMM_W){imm16[`MIPS_IMM_W-1]}}, imm16};

    always_comb begin
        id_alu_op = ALU_NOP;
        wr_en     = 1'b0;
        re1       = 1'b0;
        re2       = 1'b0;
        dst_rt    = 1'b1; // i-type writes rt
        sh_src    = '0;
        imm       = '0;
        case (op)
            OP_SPECIAL: begin
                wr_en  = 1'b1;
                re1    = 1'b1;
                re2    = 1'b1;
                dst_rt = 1'b0;
                case (funct)
                    FN_OR:   id_alu_op = ALU_OR;
                    FN_AND:  id_alu_op = ALU_AND;
                    FN_XOR:  id_alu_op = ALU_XOR;
                    FN_NOR:  id_alu_op = ALU_NOR;
                    FN_SLL:  id_alu_op = ALU_SLL;
                    FN_SRL:  id_alu_op = ALU_SRL;
                    FN_SRA:  id_alu_op = ALU_SRA;
                    FN_SLLV: id_alu_op = ALU_SLL;
                    FN_SRLV: id_alu_op = ALU_SRL;
                    FN_SLT:  id_alu_op = ALU_SLT;
                    FN_SLTU: id_alu_op = ALU_SLTU;
                    FN_ADD, FN_ADDU: id_alu_op = ALU_ADD; // no overflow trap
                    FN_SUB, FN_SUBU: id_alu_op = ALU_SUB;
                    default: wr_en = 1'b0;
                endcase
                if (funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                    re1    = 1'b0; // shamt takes the place of rs
                    sh_src = {{(`MIPS_XLEN-`MIPS_SHAMT_W){1'b0}}, shamt};
                end
            end
            OP_ORI: begin
                id_alu_op = ALU_OR;
                wr_en     = 1'b1;
                re1       = 1'b1;
                imm       = imm_zx;
            end
            OP_ANDI: begin
                id_alu_op = ALU_AND;
                wr_en     = 1'b1;
                re1       = 1'b1;
                imm       = imm_zx;
            end
            OP_LUI: begin
                id_alu_op = ALU_OR; // 0 | upper imm
                wr_en     = 1'b1;
                imm       = {imm16, {(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}};
            end
            OP_SLTI: begin
                id_alu_op = ALU_SLT;
                wr_en     = 1'b1;
                re1       = 1'b1;
                imm       = imm_sx;
            end
            OP_SLTIU: begin
                id_alu_op = ALU_SLTU; // sign-extended, unsigned compare
                wr_en     = 1'b1;
                re1       = 1'b1;
                imm       = imm_sx;
            end
            OP_ADDI, OP_ADDIU: begin
                id_alu_op = ALU_ADD;
                wr_en     = 1'b1;
                re1       = 1'b1;
                imm       = imm_sx;
            end
            default: id_alu_op = ALU_NOP; // unknown encoding
        endcase
    end

    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;
    assign id_waddr  = dst_rt ? rt : rd;
    assign id_we     = inst_vld && wr_en && (id_waddr != '0);

    // newest producer wins
    function automatic logic [`MIPS_XLEN-1:0] fwd_sel(input logic [`MIPS_REG_AW-1:0] raddr,
                                                      input logic [`MIPS_XLEN-1:0] rf_val);
        if (ex_we && (ex_waddr == raddr)) begin
            return ex_result;
        end else if (ret_we && (ret_waddr == raddr)) begin
            return ret_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        id_src1 = re1 ? fwd_sel(rs, rf_rdata1) : sh_src;
        id_src2 = re2 ? fwd_sel(rt, rf_rdata2) : imm;
    end

endmodule

//--- rtl/mips_execute.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    id_we,
    input  logic [`MIPS_REG_AW-1:0] id_waddr,
    input  mips_pkg::alu_op_e       id_alu_op,
    input  logic [`MIPS_XLEN-1:0]   id_src1,
    input  logic [`MIPS_XLEN-1:0]   id_src2,
    output logic                    ex_we,
    output logic [`MIPS_REG_AW-1:0] ex_waddr,
    output logic [`MIPS_XLEN-1:0]   ex_result
);
    import mips_pkg::*;

    logic [`MIPS_SHAMT_W-1:0] sa;
    logic                     lt_s;
    logic                     lt_u;
    logic [`MIPS_XLEN-1:0]    alu_res;

    assign sa   = id_src1[`MIPS_SHAMT_W-1:0]; // low bits only
    assign lt_s = $signed(id_src1) < $signed(id_src2);
    assign lt_u = id_src1 < id_src2;

    always_comb begin
        case (id_alu_op)
            ALU_OR: begin
                alu_res = id_src1 | id_src2;
            end
            ALU_AND: begin
                alu_res = id_src1 & id_src2;
            end
            ALU_XOR: begin
                alu_res = id_src1 ^ id_src2;
            end
            ALU_NOR: begin
                alu_res = ~(id_src1 | id_src2);
            end
            ALU_SLL: begin
                alu_res = id_src2 << sa;
            end
            ALU_SRL: begin
                alu_res = id_src2 >> sa;
            end
            ALU_SRA: begin
                alu_res = $signed(id_src2) >>> sa; // sign fill
            end
            ALU_SLT: begin
                alu_res = {{(`MIPS_XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                alu_res = {{(`MIPS_XLEN-1){1'b0}}, lt_u};
            end
            ALU_ADD: begin
                alu_res = id_src1 + id_src2;
            end
            ALU_SUB: begin
                alu_res = id_src1 - id_src2;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_we <= 1'b0;
        end else begin
            ex_we <= id_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_waddr  <= id_waddr;
        ex_result <= alu_res;
    end

endmodule

//--- rtl/mips_result.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_result (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_we,
    input  logic [`MIPS_REG_AW-1:0] ex_waddr,
    input  logic [`MIPS_XLEN-1:0]   ex_result,
    output logic                    ret_we,
    output logic [`MIPS_REG_AW-1:0] ret_waddr,
    output logic [`MIPS_XLEN-1:0]   ret_data,
    input  logic [`MIPS_REG_AW-1:0] rf_raddr1,
    input  logic [`MIPS_REG_AW-1:0] rf_raddr2,
    input  logic [`MIPS_REG_AW-1:0] dbg_raddr,
    output logic [`MIPS_XLEN-1:0]   rf_rdata1,
    output logic [`MIPS_XLEN-1:0]   rf_rdata2,
    output logic [`MIPS_XLEN-1:0]   dbg_rdata
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    // result stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_we <= 1'b0;
        end else begin
            ret_we <= ex_we;
        end
    end

    always_ff @(posedge clk) begin
        ret_waddr <= ex_waddr;
        ret_data  <= ex_result;
    end

    // all registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ret_we) begin
            regs[ret_waddr] <= ret_data;
        end
    end

    // r0 hardwired to zero on every port
    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];
    assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

//--- rtl/mips_core_top.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_core_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`MIPS_REG_AW-1:0] wb_adr,
    input  logic [`MIPS_XLEN-1:0]   wb_wdata,
    output logic [`MIPS_XLEN-1:0]   wb_rdata,
    output logic                    wb_ack
);
    import mips_pkg::*;

    logic                    issue;
    logic [`MIPS_XLEN-1:0]   issue_inst;
    logic [`MIPS_REG_AW-1:0] dbg_raddr;
    logic                    id_we;
    logic [`MIPS_REG_AW-1:0] id_waddr;
    alu_op_e                 id_alu_op;
    logic [`MIPS_XLEN-1:0]   id_src1;
    logic [`MIPS_XLEN-1:0]   id_src2;
    logic                    ex_we;
    logic [`MIPS_REG_AW-1:0] ex_waddr;
    logic [`MIPS_XLEN-1:0]   ex_result;
    logic                    ret_we;
    logic [`MIPS_REG_AW-1:0] ret_waddr;
    logic [`MIPS_XLEN-1:0]   ret_data;
    logic [`MIPS_REG_AW-1:0] rf_raddr1;
    logic [`MIPS_REG_AW-1:0] rf_raddr2;
    logic [`MIPS_XLEN-1:0]   rf_rdata1;
    logic [`MIPS_XLEN-1:0]   rf_rdata2;

    // core never stalls, so every strobe is acked at once
    assign wb_ack     = wb_cyc && wb_stb;
    assign issue      = wb_ack && wb_we; // write = one instruction
    assign issue_inst = wb_wdata;
    assign dbg_raddr  = wb_adr;          // read = one register

    mips_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issue_inst (issue_inst),
        .ex_we      (ex_we),
        .ex_waddr   (ex_waddr),
        .ex_result  (ex_result),
        .ret_we     (ret_we),
        .ret_waddr  (ret_waddr),
        .ret_data   (ret_data),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .id_we      (id_we),
        .id_waddr   (id_waddr),
        .id_alu_op  (id_alu_op),
        .id_src1    (id_src1),
        .id_src2    (id_src2)
    );

    mips_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .id_we     (id_we),
        .id_waddr  (id_waddr),
        .id_alu_op (id_alu_op),
        .id_src1   (id_src1),
        .id_src2   (id_src2),
        .ex_we     (ex_we),
        .ex_waddr  (ex_waddr),
        .ex_result (ex_result)
    );

    mips_result u_result (
        .clk       (clk),
        .rst       (rst),
        .ex_we     (ex_we),
        .ex_waddr  (ex_waddr),
        .ex_result (ex_result),
        .ret_we    (ret_we),
        .ret_waddr (ret_waddr),
        .ret_data  (ret_data),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .dbg_raddr (dbg_raddr),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .dbg_rdata (wb_rdata)
    );

endmodule

//--- dv/mips_core_properties.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_core_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    issue,
    input logic                    id_we,
    input logic                    ex_we,
    input logic                    ret_we,
    input logic [`MIPS_REG_AW-1:0] ret_waddr
);

    // a bus gap leaves a bubble in decode
    bubble_on_gap: assert property (@(posedge clk) disable iff (rst)
        id_we |-> $past(issue))
        else $error("decode write enable high without an issue in the cycle before");

    // decode already drops writes to r0
    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        !(ret_we && (ret_waddr == '0)))
        else $error("result stage write enable held for register 0");

    ex_we_after_reset: assert property (@(posedge clk) $fell(rst) |=> !ex_we)
        else $error("execute write enable high in the cycle after reset");

endmodule

bind mips_core_top mips_core_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .id_we     (id_we),
    .ex_we     (ex_we),
    .ret_we    (ret_we),
    .ret_waddr (ret_waddr)
);

//--- dv/mips_tb.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_tb;

    localparam int TIMEOUT_CYCLES = 3000; // tests need a few hundred cycles
    localparam int ACK_LIMIT      = 8;

    // architectural opcode and funct codes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] F_SLL      = 6'h00;
    localparam logic [5:0] F_SRL      = 6'h02;
    localparam logic [5:0] F_SRA      = 6'h03;
    localparam logic [5:0] F_SLLV     = 6'h04;
    localparam logic [5:0] F_SRLV     = 6'h06;
    localparam logic [5:0] F_ADD      = 6'h20;
    localparam logic [5:0] F_ADDU     = 6'h21;
    localparam logic [5:0] F_SUB      = 6'h22;
    localparam logic [5:0] F_SUBU     = 6'h23;
    localparam logic [5:0] F_AND      = 6'h24;
    localparam logic [5:0] F_OR       = 6'h25;
    localparam logic [5:0] F_XOR      = 6'h26;
    localparam logic [5:0] F_NOR      = 6'h27;
    localparam logic [5:0] F_SLT      = 6'h2a;
    localparam logic [5:0] F_SLTU     = 6'h2b;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`MIPS_REG_AW-1:0] wb_adr;
    logic [`MIPS_XLEN-1:0]   wb_wdata;
    logic [`MIPS_XLEN-1:0]   wb_rdata;
    logic                    wb_ack;

    logic [`MIPS_XLEN-1:0]   model_regs [`MIPS_NUM_REGS]; // shadow register file
    int                      seed;
    int                      cycle_count;

    mips_core_top UUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT_CYCLES) else begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic logic [15:0] random_imm();
        logic [31:0] w;
        w = $random(seed);
        return w[15:0];
    endfunction

    task automatic release_bus();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // ack and data sampled mid-cycle, returns 1 ns after the closing edge
    task automatic wait_ack(output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        assert (wb_ack) else begin
            $display("bus cycle got no ack within %0d cycles", ACK_LIMIT);
            abort_run();
        end
        data = wb_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic write_cycle(input logic [31:0] inst);
        logic [31:0] ignored;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = '0;
        wb_wdata = inst;
        wait_ack(ignored); // bus stays driven for back-to-back issue
    endtask

    task automatic read_cycle(input logic [4:0] addr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wait_ack(data);
        release_bus();
    endtask

    task automatic issue_word(input logic [31:0] inst, input int gap);
        write_cycle(inst);
        if (gap > 0) begin
            release_bus(); // gap cycles become bubbles
            repeat (gap) @(posedge clk);
            #1;
        end
    endtask

    // R-type: issue, then apply to the shadow registers
    task automatic rtype_op(input logic [5:0] fn, input int rs, input int rt, input int rd,
                            input int sa, input int gap);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = model_regs[rs[4:0]];
        b = model_regs[rt[4:0]];
        case (fn)
            F_SLL:         res = b << sa[4:0];
            F_SRL:         res = b >> sa[4:0];
            F_SRA:         res = $signed(b) >>> sa[4:0];
            F_SLLV:        res = b << a[4:0];
            F_SRLV:        res = b >> a[4:0];
            F_ADD, F_ADDU: res = a + b;
            F_SUB, F_SUBU: res = a - b;
            F_AND:         res = a & b;
            F_OR:          res = a | b;
            F_XOR:         res = a ^ b;
            F_NOR:         res = ~(a | b);
            F_SLT:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F_SLTU:        res = (a < b) ? 32'd1 : 32'd0;
            default:       res = 32'd0;
        endcase
        if (rd[4:0] != 5'd0) begin
            model_regs[rd[4:0]] = res;
        end
        issue_word({OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn}, gap);
    endtask

    task automatic itype_op(input logic [5:0] op, input int rs, input int rt,
                            input logic [15:0] imm, input int gap);
        logic [31:0] a;
        logic [31:0] zx;
        logic [31:0] sx;
        logic [31:0] res;
        a  = model_regs[rs[4:0]];
        zx = {16'h0000, imm};
        sx = {{16{imm[15]}}, imm};
        case (op)
            OP_ORI:   res = a | zx;
            OP_ANDI:  res = a & zx;
            OP_LUI:   res = {imm, 16'h0000};
            OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < sx) ? 32'd1 : 32'd0; // sign-extended, unsigned compare
            default:  res = a + sx;                  // ADDI and ADDIU
        endcase
        if (rt[4:0] != 5'd0) begin
            model_regs[rt[4:0]] = res;
        end
        issue_word({op, rs[4:0], rt[4:0], imm}, gap);
    endtask

    task automatic load_reg(input int rd, input logic [31:0] value);
        itype_op(OP_LUI, 0, rd, value[31:16], 0);
        itype_op(OP_ORI, rd, rd, value[15:0], 0);
    endtask

    // drain the pipeline, then compare every register with the model
    task automatic check_all(input string test_name);
        logic [31:0] got;
        int          r;
        release_bus();
        repeat (4) @(posedge clk);
        #1;
        for (r = 0; r < `MIPS_NUM_REGS; r++) begin
            read_cycle(r[4:0], got);
            assert (got === model_regs[r[4:0]]) else begin
                $display("[FAIL] %s r%0d expected %h actual %h", test_name, r,
                         model_regs[r[4:0]], got);
                abort_run();
            end
        end
    endtask

    task automatic reset_state();
        check_all("reset_state");
    endtask

    task automatic immediate_forms();
        itype_op(OP_ORI, 0, 1, random_imm(), 1);
        itype_op(OP_LUI, 0, 2, random_imm(), 2);
        itype_op(OP_ORI, 2, 2, random_imm(), 1);
        itype_op(OP_ANDI, 1, 3, 16'hf0f0, 1);
        itype_op(OP_ADDI, 2, 4, 16'h8001, 1);   // negative immediate
        itype_op(OP_ADDIU, 1, 5, 16'hffff, 3);
        itype_op(OP_ADDIU, 0, 6, random_imm(), 1);
        itype_op(OP_SLTI, 2, 7, random_imm(), 1);
        itype_op(OP_SLTI, 0, 8, 16'hfffe, 2);   // 0 < -2 is false
        itype_op(OP_SLTIU, 1, 9, 16'hffff, 1);
        itype_op(OP_SLTIU, 5, 10, random_imm(), 1);
        check_all("immediate_forms");
    endtask

    task automatic rtype_alu();
        load_reg(10, random_word());
        load_reg(11, random_word());
        load_reg(12, 32'h8000_0000);
        load_reg(13, 32'h0000_0001);
        load_reg(14, 32'hffff_ffff);
        load_reg(15, 32'h7fff_ffff);
        rtype_op(F_OR, 10, 11, 16, 0, 1);
        rtype_op(F_AND, 10, 11, 17, 0, 0);
        rtype_op(F_XOR, 10, 11, 18, 0, 1);
        rtype_op(F_NOR, 10, 11, 19, 0, 0);
        rtype_op(F_ADD, 10, 11, 20, 0, 2);
        rtype_op(F_ADDU, 15, 13, 21, 0, 0);  // wraps, no trap
        rtype_op(F_SUB, 10, 11, 22, 0, 1);
        rtype_op(F_SUBU, 12, 13, 23, 0, 0);
        rtype_op(F_SLT, 12, 13, 24, 0, 1);
        rtype_op(F_SLTU, 12, 13, 25, 0, 0);
        rtype_op(F_SLT, 14, 13, 26, 0, 0);   // -1 < 1 only when signed
        rtype_op(F_SLTU, 14, 13, 27, 0, 1);
        rtype_op(F_SLT, 15, 12, 28, 0, 0);
        rtype_op(F_SLTU, 15, 12, 29, 0, 0);
        rtype_op(F_SLTU, 13, 13, 30, 0, 0);
        check_all("rtype_alu");
    endtask

    task automatic shift_ops();
        load_reg(1, random_word() | 32'h8000_0000); // negative source
        load_reg(2, random_word() & 32'h7fff_ffff);
        itype_op(OP_ORI, 0, 3, 16'd35, 1);         // low five bits give 3
        rtype_op(F_SLL, 0, 1, 4, 7, 1);
        rtype_op(F_SRL, 0, 1, 5, 13, 0);
        rtype_op(F_SRA, 0, 1, 6, 13, 1);           // sign fill
        rtype_op(F_SRA, 0, 2, 7, 31, 0);
        rtype_op(F_SLLV, 3, 1, 8, 0, 2);
        rtype_op(F_SRLV, 3, 1, 9, 0, 0);
        rtype_op(F_SLLV, 2, 2, 11, 0, 1);
        rtype_op(F_SRLV, 1, 2, 12, 0, 0);
        check_all("shift_ops");
    endtask

    task automatic forwarding_chain();
        itype_op(OP_ADDIU, 0, 20, random_imm(), 0);
        rtype_op(F_ADDU, 20, 20, 21, 0, 0);  // distance one
        rtype_op(F_XOR, 21, 20, 22, 0, 0);   // one and two
        rtype_op(F_SUBU, 22, 20, 23, 0, 0);  // one and three
        rtype_op(F_OR, 21, 23, 24, 0, 0);
        itype_op(OP_ADDIU, 24, 24, random_imm(), 0);
        itype_op(OP_ADDIU, 24, 24, random_imm(), 0); // newest copy wins
        rtype_op(F_ADDU, 24, 22, 25, 0, 0);
        rtype_op(F_SLLV, 25, 24, 26, 0, 0);
        rtype_op(F_SUBU, 26, 25, 20, 0, 0);
        check_all("forwarding_chain");
    endtask

    task automatic zero_register();
        itype_op(OP_ORI, 0, 0, 16'h1234, 0);
        rtype_op(F_ADDU, 0, 0, 27, 0, 0);    // reads r0 right after the write
        itype_op(OP_ADDIU, 0, 28, 16'h0007, 0);
        rtype_op(F_OR, 28, 28, 0, 0, 0);
        rtype_op(F_OR, 0, 28, 29, 0, 0);
        rtype_op(F_SUBU, 28, 0, 30, 0, 1);
        check_all("zero_register");
    endtask

    initial begin
        seed        = 31;
        clk         = 1'b0;
        rst         = 1'b1;
        wb_adr      = '0;
        wb_wdata    = '0;
        release_bus();
        for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
            model_regs[r[4:0]] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_state();
        immediate_forms();
        rtype_alu();
        shift_ops();
        forwarding_chain();
        zero_register();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_decode.sv
rtl/mips_execute.sv
rtl/mips_result.sv
rtl/mips_core_top.sv
dv/mips_core_properties.sv
dv/mips_tb.sv

//--- run.sh
#!/bin/sh
# build and run the mips core testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module mips_tb -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmips_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
exit 0
